//--- common/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int WORD_W          = 16;                       // operand and result width
    localparam int DEBOUNCE_CYCLES = 10;                       // stable samples to confirm
    localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES);  // debounce counter width
    localparam int MUL_CNT_W       = $clog2(WORD_W);           // one step per multiplier bit

    typedef logic [3:0]           key_code_t;                  // row*4 + col
    typedef logic [3:0]           digit_t;                     // decimal 0..9
    typedef logic [WORD_W-1:0]    word_t;                      // two's complement, wraps
    typedef logic [DEB_CNT_W-1:0] deb_cnt_t;
    typedef logic [MUL_CNT_W-1:0] mul_cnt_t;

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,                                        // result is a
        OP_NEG  = 3'd1,                                        // sign change
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    typedef enum logic [1:0] {
        KIND_DIGIT,                                            // key_digit valid
        KIND_OP,                                               // key_op valid
        KIND_EQUAL                                             // issue job
    } key_kind_t;

    // keypad map positions that are not digits
    localparam key_code_t EMPTY_KEY = 4'hE;                    // yields no event
    localparam key_code_t KEY_ADD   = 4'h3;
    localparam key_code_t KEY_SUB   = 4'h7;
    localparam key_code_t KEY_MUL   = 4'hB;
    localparam key_code_t KEY_EQUAL = 4'hC;
    localparam key_code_t KEY_NEG   = 4'hF;

    localparam deb_cnt_t DEB_LAST = deb_cnt_t'(DEBOUNCE_CYCLES - 1);  // final debounce count
    localparam mul_cnt_t MUL_LAST = mul_cnt_t'(WORD_W - 1);           // final shift-add step

endpackage

`default_nettype wire

//--- keypad/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner (
    input  logic                clk,
    input  logic                nRST,                 // async active-low reset
    input  logic [3:0]          row_in,               // keypad rows with pull-ups
    output logic [3:0]          col_out,              // one column driven low
    output logic                key_req,              // event to entry stage
    input  logic                key_ack,
    output calc_pkg::key_kind_t key_kind,
    output calc_pkg::digit_t    key_digit,
    output calc_pkg::op_t       key_op
);

    typedef enum logic [2:0] {
        SCAN_COL,                                     // walk columns until a row drops
        DEBOUNCE,                                     // count stable low samples
        CONFIRM,                                      // decode and raise req
        WAIT_ACK,                                     // hold req until ack and release
        WAIT_RELEASE                                  // empty key gives no event
    } scan_state_t;

    scan_state_t         state;
    logic [1:0]          col_idx;                     // active column
    calc_pkg::deb_cnt_t  deb_cnt;                     // low samples after the first
    logic                row_hit;                     // some row pulled low
    calc_pkg::key_code_t code;                        // encoded key position
    calc_pkg::key_kind_t dec_kind;
    calc_pkg::digit_t    dec_digit;
    calc_pkg::op_t       dec_op;
    logic                load_event;                  // confirmed key becomes an event

    assign row_hit = ~&row_in;

    always_comb begin
        col_out          = 4'b1111;
        col_out[col_idx] = 1'b0;                      // drive only the scanned column
    end

    // lowest low row wins when several rows read low
    function automatic calc_pkg::key_code_t encode_key(input logic [3:0] rows,
                                                       input logic [1:0] col);
        logic [1:0] row_idx;
        logic       found;
        row_idx = 2'd0;
        found   = 1'b0;
        for (int r = 0; r < 4; r++) begin
            if (!rows[r] && !found) begin
                row_idx = 2'(r);
                found   = 1'b1;
            end
        end
        return found ? {row_idx, col} : calc_pkg::EMPTY_KEY;
    endfunction

    assign code = encode_key(row_in, col_idx);

    always_comb begin
        dec_kind  = calc_pkg::KIND_DIGIT;
        dec_digit = 4'd0;
        dec_op    = calc_pkg::OP_NONE;
        case (code)
            4'h0: dec_digit = 4'd1;
            4'h1: dec_digit = 4'd2;
            4'h2: dec_digit = 4'd3;
            4'h4: dec_digit = 4'd4;
            4'h5: dec_digit = 4'd5;
            4'h6: dec_digit = 4'd6;
            4'h8: dec_digit = 4'd7;
            4'h9: dec_digit = 4'd8;
            4'hA: dec_digit = 4'd9;
            4'hD: dec_digit = 4'd0;                   // zero sits below the digits
            calc_pkg::KEY_ADD: begin
                dec_kind = calc_pkg::KIND_OP;
                dec_op   = calc_pkg::OP_ADD;
            end
            calc_pkg::KEY_SUB: begin
                dec_kind = calc_pkg::KIND_OP;
                dec_op   = calc_pkg::OP_SUB;
            end
            calc_pkg::KEY_MUL: begin
                dec_kind = calc_pkg::KIND_OP;
                dec_op   = calc_pkg::OP_MUL;
            end
            calc_pkg::KEY_NEG: begin
                dec_kind = calc_pkg::KIND_OP;
                dec_op   = calc_pkg::OP_NEG;
            end
            calc_pkg::KEY_EQUAL: dec_kind = calc_pkg::KIND_EQUAL;
            default: ;                                // empty key
        endcase
    end

    // wait for the previous ack to drop before a new req
    assign load_event = (state == CONFIRM) && row_hit && (code != calc_pkg::EMPTY_KEY)
                        && !key_ack;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= SCAN_COL;
            col_idx <= 2'd0;
            deb_cnt <= '0;
            key_req <= 1'b0;
        end else begin
            case (state)
                SCAN_COL: begin
                    if (row_hit) begin
                        deb_cnt <= '0;                // first low sample
                        state   <= DEBOUNCE;
                    end else begin
                        col_idx <= col_idx + 2'd1;    // wraps from 3 to 0
                    end
                end
                DEBOUNCE: begin
                    if (!row_hit) begin
                        state <= SCAN_COL;            // a bounce restarts the count
                    end else if (deb_cnt == calc_pkg::DEB_LAST) begin
                        state <= CONFIRM;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                CONFIRM: begin
                    if (load_event) begin
                        key_req <= 1'b1;
                        state   <= WAIT_ACK;
                    end else if (!row_hit || code == calc_pkg::EMPTY_KEY) begin
                        state <= WAIT_RELEASE;
                    end
                end
                WAIT_ACK: begin
                    if (key_ack && !row_hit) begin    // held key gives one event
                        key_req <= 1'b0;
                        state   <= SCAN_COL;
                    end
                end
                WAIT_RELEASE: begin
                    if (!row_hit) state <= SCAN_COL;
                end
                default: state <= SCAN_COL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_event) begin                         // payload fixed while req high
            key_kind  <= dec_kind;
            key_digit <= dec_digit;
            key_op    <= dec_op;
        end
    end

    a_req_until_ack: assert property (@(posedge clk) disable iff (!nRST)
        $fell(key_req) |-> $past(key_ack));

endmodule

`default_nettype wire

//--- hw/operand_entry.sv
`timescale 1ns/1ps
`default_nettype none

module operand_entry (
    input  logic                clk,
    input  logic                nRST,                 // async, active low
    input  logic                key_req,              // event from scanner
    output logic                key_ack,
    input  calc_pkg::key_kind_t key_kind,
    input  calc_pkg::digit_t    key_digit,
    input  calc_pkg::op_t       key_op,
    output logic                job_req,              // job to arith stage
    input  logic                job_ack,
    output calc_pkg::word_t     job_a,
    output calc_pkg::word_t     job_b,
    output calc_pkg::op_t       job_op
);

    typedef enum logic {
        ENTER_A,
        ENTER_B
    } entry_state_t;

    entry_state_t    state;
    calc_pkg::word_t cur;                             // operand being keyed
    calc_pkg::word_t opnd_a;                          // a, parked during b entry
    calc_pkg::op_t   op_r;                            // stored operator
    logic            job_pend;                        // job loaded, req next cycle
    logic            job_free;                        // job slot empty, handshake closed
    logic            is_equal;
    logic            accept;                          // take this key event now

    assign is_equal = (key_kind == calc_pkg::KIND_EQUAL);
    assign job_free = !job_req && !job_ack && !job_pend;
    // equals stalls under back-pressure, digits and operators still go through
    assign accept   = key_req && !key_ack && (!is_equal || job_free);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= ENTER_A;
            cur      <= '0;
            opnd_a   <= '0;
            op_r     <= calc_pkg::OP_NONE;
            key_ack  <= 1'b0;
            job_req  <= 1'b0;
            job_pend <= 1'b0;
        end else begin
            if (accept) begin
                key_ack <= 1'b1;
            end else if (!key_req) begin
                key_ack <= 1'b0;                      // four-phase return
            end

            job_pend <= accept && is_equal;
            if (job_pend) begin
                job_req <= 1'b1;
            end else if (job_req && job_ack) begin
                job_req <= 1'b0;
            end

            if (accept) begin
                case (key_kind)
                    calc_pkg::KIND_DIGIT: begin
                        cur <= cur * calc_pkg::word_t'(10) + calc_pkg::word_t'(key_digit);
                    end
                    calc_pkg::KIND_OP: begin
                        if (key_op == calc_pkg::OP_NEG) begin
                            cur <= -cur;              // sign of current operand
                        end else if (key_op != calc_pkg::OP_NONE) begin
                            op_r <= key_op;           // later operator replaces
                            if (state == ENTER_A) begin
                                opnd_a <= cur;
                                cur    <= '0;         // b starts empty
                                state  <= ENTER_B;
                            end
                        end
                    end
                    calc_pkg::KIND_EQUAL: begin
                        cur   <= '0;                  // fresh a for next expression
                        op_r  <= calc_pkg::OP_NONE;
                        state <= ENTER_A;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_equal) begin
            if (state == ENTER_B) begin
                job_a  <= opnd_a;
                job_b  <= cur;
                job_op <= op_r;
            end else begin
                job_a  <= cur;                        // no operator, result is a
                job_b  <= '0;
                job_op <= calc_pkg::OP_NONE;
            end
        end
    end

    a_job_stable: assert property (@(posedge clk) disable iff (!nRST)
        job_req && $past(job_req) |-> $stable(job_a) && $stable(job_b) && $stable(job_op));

endmodule

`default_nettype wire

//--- hw/arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
    input  logic            clk,
    input  logic            nRST,                     // async, active low
    input  logic            job_req,                  // job from entry
    output logic            job_ack,
    input  calc_pkg::word_t job_a,
    input  calc_pkg::word_t job_b,
    input  calc_pkg::op_t   job_op,
    output logic            res_req,                  // result to outside
    input  logic            res_ack,
    output calc_pkg::word_t res_value
);

    typedef enum logic [1:0] {
        IDLE,                                         // ready for a job
        MUL_STEP,                                     // shift-add loop
        EXEC,                                         // form result
        RESULT                                        // hold under res_req
    } arith_state_t;

    arith_state_t       state;
    calc_pkg::word_t    a_r;                          // multiplicand, shifts left
    calc_pkg::word_t    b_r;                          // multiplier, shifts right
    calc_pkg::word_t    acc;                          // low bits of product
    calc_pkg::op_t      op_r;
    calc_pkg::mul_cnt_t step;
    calc_pkg::word_t    result_next;
    logic               take;                         // latch job this cycle

    // no new job while a result is out or its ack is still high
    assign take = (state == IDLE) && job_req && !job_ack && !res_ack;

    always_comb begin
        case (op_r)
            calc_pkg::OP_ADD: result_next = a_r + b_r;
            calc_pkg::OP_SUB: result_next = a_r - b_r;
            calc_pkg::OP_MUL: result_next = acc;
            default:          result_next = a_r;      // pass-through
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            job_ack <= 1'b0;
            res_req <= 1'b0;
            step    <= '0;
        end else begin
            if (take) begin
                job_ack <= 1'b1;                      // operands latched, entry free
            end else if (!job_req) begin
                job_ack <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (take) begin
                        step  <= '0;
                        state <= (job_op == calc_pkg::OP_MUL) ? MUL_STEP : EXEC;
                    end
                end
                MUL_STEP: begin
                    step <= step + 1'b1;
                    if (step == calc_pkg::MUL_LAST) state <= EXEC;
                end
                EXEC: begin
                    res_req <= 1'b1;
                    state   <= RESULT;
                end
                RESULT: begin
                    if (res_ack) begin
                        res_req <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            a_r  <= job_a;
            b_r  <= job_b;
            op_r <= job_op;
            acc  <= '0;
        end else if (state == MUL_STEP) begin
            if (b_r[0]) acc <= acc + a_r;             // wraps mod 2^16
            a_r <= a_r << 1;
            b_r <= b_r >> 1;
        end
        if (state == EXEC) res_value <= result_next;  // only while res_req low
    end

    a_res_until_ack: assert property (@(posedge clk) disable iff (!nRST)
        $fell(res_req) |-> $past(res_ack));

endmodule

`default_nettype wire

//--- hw/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top (
    input  logic            clk,
    input  logic            nRST,                     // async, active low
    input  logic [3:0]      row_in,                   // keypad rows
    output logic [3:0]      col_out,                  // keypad columns
    output logic            res_req,
    input  logic            res_ack,
    output calc_pkg::word_t res_value
);

    logic                key_req;                     // scanner -> entry
    logic                key_ack;
    calc_pkg::key_kind_t key_kind;
    calc_pkg::digit_t    key_digit;
    calc_pkg::op_t       key_op;
    logic                job_req;                     // entry -> arith
    logic                job_ack;
    calc_pkg::word_t     job_a;
    calc_pkg::word_t     job_b;
    calc_pkg::op_t       job_op;

    keypad_scanner u_keypad_scanner (
        .clk(clk), .nRST(nRST),
        .row_in(row_in), .col_out(col_out),
        .key_req(key_req), .key_ack(key_ack),
        .key_kind(key_kind), .key_digit(key_digit), .key_op(key_op)
    );

    operand_entry u_operand_entry (
        .clk(clk), .nRST(nRST),
        .key_req(key_req), .key_ack(key_ack),
        .key_kind(key_kind), .key_digit(key_digit), .key_op(key_op),
        .job_req(job_req), .job_ack(job_ack),
        .job_a(job_a), .job_b(job_b), .job_op(job_op)
    );

    arith_unit u_arith_unit (
        .clk(clk), .nRST(nRST),
        .job_req(job_req), .job_ack(job_ack),
        .job_a(job_a), .job_b(job_b), .job_op(job_op),
        .res_req(res_req), .res_ack(res_ack), .res_value(res_value)
    );

endmodule

`default_nettype wire

//--- tb/keypad_matrix_model.sv
`timescale 1ns/1ps
`default_nettype none

// 4x4 switch matrix with pull-ups on the rows
// one key at most is closed at a time
module keypad_matrix_model (
    input  logic [3:0]          col_out,              // from scanner, one column low
    input  calc_pkg::key_code_t key_code,             // row*4 + col of the held key
    input  logic                pressed,              // switch closed
    output logic [3:0]          row_in                // to scanner
);

    logic [1:0] key_row;                              // upper bits of the code
    logic [1:0] key_col;                              // lower bits of the code
    logic       col_active;                           // held key's column driven low

    assign key_row    = key_code[3:2];
    assign key_col    = key_code[1:0];
    assign col_active = !col_out[key_col];

    always_comb begin
        row_in = 4'b1111;                             // idle rows read high
        if (pressed && col_active) begin
            row_in[key_row] = 1'b0;                   // closed switch shorts row to column
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_calc_top;

    localparam int HOLD_CYCLES = (calc_pkg::DEBOUNCE_CYCLES + 8) * 4;  // scan rounds of 4 cols
    localparam int BOUNCE_CYCLES = 6;                 // well short of the debounce count
    localparam int WAIT_LIMIT  = 2000;                // per wait loop

    logic                clk;
    logic                nRST;
    logic [3:0]          row_in;
    logic [3:0]          col_out;
    logic                res_req;
    logic                res_ack;
    calc_pkg::word_t     res_value;
    calc_pkg::key_code_t key_code;                    // key held on the matrix
    logic                pressed;

    int                  seed;
    int                  checks;
    int                  errors;
    int                  err_mark;                    // errors when the test began

    calc_pkg::word_t     m_cur;                       // operand being keyed
    calc_pkg::word_t     m_a;                         // parked a
    calc_pkg::op_t       m_op;
    logic                m_in_b;
    calc_pkg::word_t     expected[$];                 // results in issue order

    calc_top u_calc_top (
        .clk(clk), .nRST(nRST),
        .row_in(row_in), .col_out(col_out),
        .res_req(res_req), .res_ack(res_ack), .res_value(res_value)
    );

    keypad_matrix_model u_keypad_matrix_model (
        .col_out(col_out), .key_code(key_code), .pressed(pressed), .row_in(row_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);             // non-negative
    endfunction

    // position of each digit on the keypad
    function automatic calc_pkg::key_code_t digit_code(input int d);
        case (d)
            1:       return 4'h0;
            2:       return 4'h1;
            3:       return 4'h2;
            4:       return 4'h4;
            5:       return 4'h5;
            6:       return 4'h6;
            7:       return 4'h8;
            8:       return 4'h9;
            9:       return 4'hA;
            default: return 4'hD;                     // zero
        endcase
    endfunction

    task automatic model_digit(input int d);
        m_cur = m_cur * 16'd10 + calc_pkg::word_t'(d);
    endtask

    task automatic model_op(input calc_pkg::op_t op);
        if (op == calc_pkg::OP_NEG) begin
            m_cur = -m_cur;
        end else begin
            m_op = op;                                // a later operator replaces
            if (!m_in_b) begin
                m_a    = m_cur;
                m_cur  = '0;
                m_in_b = 1'b1;
            end
        end
    endtask

    task automatic model_equal();
        calc_pkg::word_t r;
        if (!m_in_b) r = m_cur;                       // no operator
        else if (m_op == calc_pkg::OP_ADD) r = m_a + m_cur;
        else if (m_op == calc_pkg::OP_SUB) r = m_a - m_cur;
        else r = m_a * m_cur;                         // low 16 bits
        expected.push_back(r);
        m_cur  = '0;
        m_a    = '0;
        m_op   = calc_pkg::OP_NONE;
        m_in_b = 1'b0;
    endtask

    task automatic press_key(input calc_pkg::key_code_t code, input int hold);
        @(negedge clk);
        key_code = code;
        pressed  = 1'b1;
        repeat (hold) @(negedge clk);
        pressed  = 1'b0;
        repeat (4 + rand_below(8)) @(negedge clk);    // random release gap
    endtask

    task automatic enter_digit(input int d);
        press_key(digit_code(d), HOLD_CYCLES);
        model_digit(d);
    endtask

    task automatic enter_number(input int ndig);
        repeat (ndig) enter_digit(rand_below(10));
    endtask

    task automatic enter_op(input calc_pkg::op_t op);
        calc_pkg::key_code_t code;
        case (op)
            calc_pkg::OP_ADD: code = calc_pkg::KEY_ADD;
            calc_pkg::OP_SUB: code = calc_pkg::KEY_SUB;
            calc_pkg::OP_MUL: code = calc_pkg::KEY_MUL;
            default:          code = calc_pkg::KEY_NEG;
        endcase
        press_key(code, HOLD_CYCLES);
        model_op(op);
    endtask

    task automatic enter_equal();
        press_key(calc_pkg::KEY_EQUAL, HOLD_CYCLES);
        model_equal();
    endtask

    // waits for a result, checks it, acks after a delay
    task automatic take_result(input string name, input int delay);
        int              waited;
        calc_pkg::word_t exp;
        waited = 0;
        while (!res_req && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (res_req && expected.size() > 0) else begin
            $display("%s: no result within %0d cycles", name, WAIT_LIMIT);
            errors++;
        end
        if (res_req && expected.size() > 0) begin
            exp = expected.pop_front();
            checks++;
            assert (res_value == exp) else begin
                $display("MISMATCH %s expected %h actual %h", name, exp, res_value);
                errors++;
            end
            repeat (delay) @(negedge clk);
            res_ack = 1'b1;
            waited  = 0;
            while (res_req && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            assert (!res_req) else begin
                $display("%s: res_req stayed high after res_ack", name);
                errors++;
            end
            res_ack = 1'b0;                           // four-phase return
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-12s %s", name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    initial begin
        seed     = 28689;
        checks   = 0;
        errors   = 0;
        err_mark = 0;
        nRST     = 1'b0;
        res_ack  = 1'b0;
        pressed  = 1'b0;
        key_code = calc_pkg::EMPTY_KEY;
        m_cur    = '0;
        m_a      = '0;
        m_op     = calc_pkg::OP_NONE;
        m_in_b   = 1'b0;
        repeat (16) @(negedge clk);
        nRST = 1'b1;

        repeat (50) begin                             // idle, no key
            @(negedge clk);
            checks++;
            assert (!res_req && $countones(~col_out) == 1) else begin
                $display("reset_state: res_req high or col_out %b not one low column", col_out);
                errors++;
            end
        end
        finish_test("reset_state");

        repeat (30) begin
            enter_number(1 + rand_below(4));
            enter_op((rand_below(2) != 0) ? calc_pkg::OP_SUB : calc_pkg::OP_ADD);
            enter_number(1 + rand_below(4));
            enter_equal();
            take_result("add_sub", rand_below(6));
        end
        finish_test("add_sub");

        repeat (12) begin
            enter_number(1 + rand_below(4));
            if (rand_below(2) != 0) enter_op(calc_pkg::OP_NEG);
            if (rand_below(4) == 0) enter_op(calc_pkg::OP_ADD);  // replaced by multiply
            enter_op(calc_pkg::OP_MUL);
            enter_number(1 + rand_below(4));
            if (rand_below(2) != 0) enter_op(calc_pkg::OP_NEG);
            enter_equal();
            take_result("mul_neg", rand_below(6));
        end
        finish_test("mul_neg");

        repeat (4) begin
            enter_number(1 + rand_below(4));
            enter_equal();                            // result is a
            take_result("equal_only", rand_below(6));
            enter_digit(rand_below(10));
            press_key(calc_pkg::EMPTY_KEY, HOLD_CYCLES);  // no event
            enter_digit(rand_below(10));
            enter_op(calc_pkg::OP_ADD);
            enter_number(1 + rand_below(3));
            enter_equal();
            take_result("empty_key", rand_below(6));
        end
        finish_test("empty_key");

        enter_digit(rand_below(10));
        press_key(digit_code(rand_below(10)), BOUNCE_CYCLES);  // too short, dropped
        enter_digit(rand_below(10));
        enter_op(calc_pkg::OP_ADD);
        enter_number(2);
        enter_equal();
        take_result("bounce", 2);
        enter_number(3);                              // first expression, result held
        enter_op(calc_pkg::OP_MUL);
        enter_number(2);
        enter_equal();
        enter_number(2);                              // second keyed while res_ack is off
        enter_op(calc_pkg::OP_SUB);
        enter_number(3);
        enter_equal();
        take_result("backpressure", 300);
        take_result("backpressure", rand_below(6));
        finish_test("bounce_bp");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
common/calc_pkg.sv
keypad/keypad_scanner.sv
hw/operand_entry.sv
hw/arith_unit.sv
hw/calc_top.sv
tb/keypad_matrix_model.sv
tb/tb_calc_top.sv

//--- Makefile
# Verilator build and run for the keypad calculator testbench

VERILATOR  ?= verilator
TOP        := tb_calc_top
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
PASS_MSG   := === PASS ===

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
